/* hdl/vga_consts.svh */
`ifndef VGA_CONSTS_SVH
`define VGA_CONSTS_SVH

////////////////////////////////////////////////////////////
// 640x480 at 60 Hz, pixel clock rate
////////////////////////////////////////////////////////////

`define VGA_H_VIDEO 640
`define VGA_H_FRONT 16
`define VGA_H_SYNC 96
`define VGA_H_BACK 48
`define VGA_H_TOTAL (`VGA_H_VIDEO + `VGA_H_FRONT + `VGA_H_SYNC + `VGA_H_BACK)

`define VGA_V_VIDEO 480
`define VGA_V_FRONT 10
`define VGA_V_SYNC 2
`define VGA_V_BACK 33
`define VGA_V_TOTAL (`VGA_V_VIDEO + `VGA_V_FRONT + `VGA_V_SYNC + `VGA_V_BACK)

`define VGA_H_SYNC_POL 1'b0 // Active low.
`define VGA_V_SYNC_POL 1'b0 // Active low.

////////////////////////////////////////////////////////////
// Frame buffer and host queue
////////////////////////////////////////////////////////////

`define FB_SCALE_LOG2 2 // Each stored pixel is a 4x4 block.
`define FB_WIDTH 160
`define FB_HEIGHT 120
`define FB_DEPTH (`FB_WIDTH * `FB_HEIGHT)

`define WFIFO_DEPTH 8

`endif

/* hdl/vga_pkg.sv */
`default_nettype none

package vga_pkg;

    ////////////////////////////////////////////////////////////
    // Raster positions
    ////////////////////////////////////////////////////////////

    typedef logic [9:0] h_count_t;
    typedef logic [9:0] v_count_t;

    ////////////////////////////////////////////////////////////
    // Frame buffer words
    ////////////////////////////////////////////////////////////

    typedef logic [14:0] fb_addr_t; // Covers 160x120 words.
    typedef logic [7:0] pixel_t; // RGB 3-3-2.

    // One pending host write.
    typedef struct packed {
        fb_addr_t addr;
        pixel_t   pixel;
    } fb_write_t;

endpackage

`default_nettype wire

/* hdl/vga_timing.sv */
`default_nettype none

`include "vga_consts.svh"

module vga_timing import vga_pkg::*; (
    input  wire       clk,
    input  wire       reset,
    output h_count_t  h_count_next,
    output v_count_t  v_count_next,
    output logic      h_sync,
    output logic      v_sync,
    output logic      will_display
);

    localparam h_count_t H_TOTAL = h_count_t'(`VGA_H_TOTAL);
    localparam h_count_t H_LAST = h_count_t'(`VGA_H_TOTAL - 1);
    localparam h_count_t H_SYNC_START = h_count_t'(`VGA_H_VIDEO + `VGA_H_FRONT);
    localparam h_count_t H_SYNC_END = h_count_t'(`VGA_H_VIDEO + `VGA_H_FRONT + `VGA_H_SYNC);

    localparam v_count_t V_TOTAL = v_count_t'(`VGA_V_TOTAL);
    localparam v_count_t V_LAST = v_count_t'(`VGA_V_TOTAL - 1);
    localparam v_count_t V_SYNC_START = v_count_t'(`VGA_V_VIDEO + `VGA_V_FRONT);
    localparam v_count_t V_SYNC_END = v_count_t'(`VGA_V_VIDEO + `VGA_V_FRONT + `VGA_V_SYNC);

    h_count_t h_count;
    v_count_t v_count;

    ////////////////////////////////////////////////////////////
    // Look-ahead position
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (h_count == H_LAST) begin
            h_count_next = '0;
            if (v_count == V_LAST)
                v_count_next = '0;
            else
                v_count_next = v_count + v_count_t'(1);
        end else begin
            h_count_next = h_count + h_count_t'(1);
            v_count_next = v_count; // Row holds within a line.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            h_count <= '0;
            v_count <= '0;
        end else begin
            h_count <= h_count_next;
            v_count <= v_count_next;
        end
    end

    assign h_sync = (h_count >= H_SYNC_START && h_count < H_SYNC_END) ?
        `VGA_H_SYNC_POL : ~`VGA_H_SYNC_POL;
    assign v_sync = (v_count >= V_SYNC_START && v_count < V_SYNC_END) ?
        `VGA_V_SYNC_POL : ~`VGA_V_SYNC_POL;

    assign will_display = (h_count_next < h_count_t'(`VGA_H_VIDEO)) &&
        (v_count_next < v_count_t'(`VGA_V_VIDEO));

    counters_in_range: assert property (@(posedge clk) disable iff (reset)
        h_count < H_TOTAL && v_count < V_TOTAL);

endmodule

`default_nettype wire

/* hdl/scanout_fetch.sv */
`default_nettype none

`include "vga_consts.svh"

module scanout_fetch import vga_pkg::*; (
    input  wire           clk,
    input  wire           reset,
    input  wire h_count_t h_count_next,
    input  wire v_count_t v_count_next,
    input  wire           will_display,
    input  wire           h_sync,
    input  wire           v_sync,
    input  wire pixel_t   mem_rdata,
    output logic          scan_rd,
    output fb_addr_t      scan_addr,
    output pixel_t        rgb,
    output logic          de,
    output logic          hsync,
    output logic          vsync
);

    logic display_d; // Registered position is on screen.
    logic rd_d; // Read data is valid this cycle.

    ////////////////////////////////////////////////////////////
    // Read request from the look-ahead position
    ////////////////////////////////////////////////////////////

    assign scan_addr = fb_addr_t'(v_count_next >> `FB_SCALE_LOG2) * fb_addr_t'(`FB_WIDTH) +
        fb_addr_t'(h_count_next >> `FB_SCALE_LOG2);

    // One fetch at the first column of each block.
    assign scan_rd = will_display && (h_count_next[`FB_SCALE_LOG2-1:0] == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            display_d <= 1'b0;
            rd_d      <= 1'b0;
        end else begin
            display_d <= will_display;
            rd_d      <= scan_rd;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            rgb   <= '0;
            de    <= 1'b0;
            hsync <= ~`VGA_H_SYNC_POL;
            vsync <= ~`VGA_V_SYNC_POL;
        end else begin
            de    <= display_d;
            hsync <= h_sync; // Same latency as de.
            vsync <= v_sync;
            if (!display_d)
                rgb <= '0; // Blank outside video.
            else if (rd_d)
                rgb <= mem_rdata; // Held for the rest of the block.
        end
    end

endmodule

`default_nettype wire

/* hdl/write_fifo.sv */
`default_nettype none

`include "vga_consts.svh"

module write_fifo import vga_pkg::*; #(
    parameter int DEPTH = `WFIFO_DEPTH
) (
    input  wire            clk,
    input  wire            reset,
    input  wire            push,
    input  wire fb_write_t push_data,
    output logic           full,
    input  wire            pop,
    output logic           empty,
    output fb_write_t      head
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    fb_write_t entries [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic do_push;
    logic do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    assign head = entries[rd_ptr];

    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push)
            entries[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop)
                rd_ptr <= ptr_inc(rd_ptr);
            unique case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither.
            endcase
        end
    end

    no_push_when_full: assert property (@(posedge clk) disable iff (reset) push |-> !full);
    no_pop_when_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

`default_nettype wire

/* hdl/fb_arbiter.sv */
`default_nettype none

module fb_arbiter import vga_pkg::*; (
    input  wire            clk,
    input  wire            reset,
    input  wire            scan_rd,
    input  wire fb_addr_t  scan_addr,
    input  wire            wq_empty,
    input  wire fb_write_t wq_head,
    output logic           wq_pop,
    output logic           mem_en,
    output logic           mem_we,
    output fb_addr_t       mem_addr,
    output pixel_t         mem_wdata
);

    logic write_grant;

    ////////////////////////////////////////////////////////////
    // Fixed priority, scanout first
    ////////////////////////////////////////////////////////////

    // Queue gets every port cycle scanout leaves idle.
    assign write_grant = !scan_rd && !wq_empty;

    assign wq_pop = write_grant;
    assign mem_en = scan_rd || write_grant;
    assign mem_we = write_grant;

    always_comb begin
        if (scan_rd)
            mem_addr = scan_addr;
        else
            mem_addr = wq_head.addr;
    end

    assign mem_wdata = wq_head.pixel; // Only sampled on writes.

    // A read never loses its cycle to the queue.
    pop_excludes_read: assert property (@(posedge clk) disable iff (reset)
        wq_pop |-> !scan_rd);

    // Every memory write retires one queued entry.
    write_needs_pop: assert property (@(posedge clk) disable iff (reset)
        mem_we |-> wq_pop);

endmodule

`default_nettype wire

/* hdl/frame_buffer.sv */
`default_nettype none

`include "vga_consts.svh"

module frame_buffer import vga_pkg::*; (
    input  wire           clk,
    input  wire           en,
    input  wire           we,
    input  wire fb_addr_t addr,
    input  wire pixel_t   wdata,
    output pixel_t        rdata
);

    pixel_t mem [`FB_DEPTH];

    ////////////////////////////////////////////////////////////
    // Single port, one access per cycle
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (en) begin
            if (we)
                mem[addr] <= wdata;
            else
                rdata <= mem[addr]; // Valid the next cycle.
        end
    end

endmodule

`default_nettype wire

/* hdl/display_top.sv */
`default_nettype none

`include "vga_consts.svh"

module display_top import vga_pkg::*; (
    input  wire           clk,
    input  wire           reset,
    input  wire           host_wr,
    input  wire fb_addr_t host_addr,
    input  wire pixel_t   host_pixel,
    output logic          host_full,
    output pixel_t        rgb,
    output logic          de,
    output logic          hsync,
    output logic          vsync
);

    h_count_t h_count_next;
    v_count_t v_count_next;
    logic h_sync;
    logic v_sync;
    logic will_display;

    logic scan_rd;
    fb_addr_t scan_addr;

    fb_write_t host_entry;
    fb_write_t wq_head;
    logic wq_empty;
    logic wq_pop;

    logic mem_en;
    logic mem_we;
    fb_addr_t mem_addr;
    pixel_t mem_wdata;
    pixel_t mem_rdata;

    ////////////////////////////////////////////////////////////
    // Raster and scanout
    ////////////////////////////////////////////////////////////

    vga_timing vga_timing_inst (
        .clk          (clk),
        .reset        (reset),
        .h_count_next (h_count_next),
        .v_count_next (v_count_next),
        .h_sync       (h_sync),
        .v_sync       (v_sync),
        .will_display (will_display)
    );

    scanout_fetch scanout_fetch_inst (
        .clk          (clk),
        .reset        (reset),
        .h_count_next (h_count_next),
        .v_count_next (v_count_next),
        .will_display (will_display),
        .h_sync       (h_sync),
        .v_sync       (v_sync),
        .mem_rdata    (mem_rdata),
        .scan_rd      (scan_rd),
        .scan_addr    (scan_addr),
        .rgb          (rgb),
        .de           (de),
        .hsync        (hsync),
        .vsync        (vsync)
    );

    ////////////////////////////////////////////////////////////
    // Host writes and the shared port
    ////////////////////////////////////////////////////////////

    assign host_entry = '{addr: host_addr, pixel: host_pixel};

    write_fifo #(
        .DEPTH (`WFIFO_DEPTH)
    ) write_fifo_inst (
        .clk       (clk),
        .reset     (reset),
        .push      (host_wr),
        .push_data (host_entry),
        .full      (host_full),
        .pop       (wq_pop),
        .empty     (wq_empty),
        .head      (wq_head)
    );

    fb_arbiter fb_arbiter_inst (
        .clk       (clk),
        .reset     (reset),
        .scan_rd   (scan_rd),
        .scan_addr (scan_addr),
        .wq_empty  (wq_empty),
        .wq_head   (wq_head),
        .wq_pop    (wq_pop),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    frame_buffer frame_buffer_inst (
        .clk   (clk),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

/* verification/display_tb.sv */
`default_nettype none

`include "vga_consts.svh"

module display_tb import vga_pkg::*; ();

    localparam int FRAME_CYCLES = `VGA_H_TOTAL * `VGA_V_TOTAL;
    localparam int ROUNDS = 3;
    localparam int SCALE = 1 << `FB_SCALE_LOG2;
    localparam longint TIMEOUT = (2 * `FB_DEPTH + (ROUNDS * 3 + 2) * FRAME_CYCLES) * 4;
    localparam int IDLE = 0;
    localparam int FILL = 1;
    localparam int HAMMER = 2; // Strobe whenever the queue has room.
    localparam int RANDOM = 3;

    logic clk = 1'b0;
    logic reset;
    logic host_wr;
    fb_addr_t host_addr;
    pixel_t host_pixel;
    logic host_full;
    pixel_t rgb;
    logic de;
    logic hsync;
    logic vsync;

    pixel_t model [`FB_DEPTH];
    int q_count = 0; // Queue occupancy after the last edge.
    int fill_addr = 0;
    int mode = IDLE;
    logic check_en = 1'b0;
    logic full_seen = 1'b0;
    int checked = 0;

    int t = 0;
    int hfall_t = 0;
    int defall_t = 0;
    int lines = 0;
    int de_lines = 0;
    int row = 0;
    int col = 0;
    logic hsync_d = 1'b1;
    logic vsync_d = 1'b1;
    logic de_d = 1'b0;
    logic line_de = 1'b0;
    logic new_frame = 1'b1;
    logic vfall_seen = 1'b0;

    always #2 clk = ~clk;

    display_top display_top_inst (
        .clk        (clk),
        .reset      (reset),
        .host_wr    (host_wr),
        .host_addr  (host_addr),
        .host_pixel (host_pixel),
        .host_full  (host_full),
        .rgb        (rgb),
        .de         (de),
        .hsync      (hsync),
        .vsync      (vsync)
    );

    ////////////////////////////////////////////////////////////
    // Reporting and compares
    ////////////////////////////////////////////////////////////

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_h_period(input string name, input h_count_t exp, input h_count_t act);
        if (act !== exp)
            report_failure($sformatf("FAILED at %0t: %s expected %0d, got %0d",
                $time, name, exp, act));
    endtask

    task automatic check_v_period(input string name, input v_count_t exp, input v_count_t act);
        if (act !== exp)
            report_failure($sformatf("FAILED at %0t: %s expected %0d, got %0d",
                $time, name, exp, act));
    endtask

    task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
        if (act !== exp)
            report_failure($sformatf("FAILED at %0t: %s expected 8'h%02h, got 8'h%02h",
                $time, name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_failure($sformatf("FAILED at %0t: %s expected %b, got %b",
                $time, name, exp, act));
    endtask

    task automatic expect_reset_state();
        check_flag("de", 1'b0, de);
        check_pixel("rgb", '0, rgb);
        check_flag("hsync", 1'b1, hsync);
        check_flag("vsync", 1'b1, vsync);
        check_flag("host_full", 1'b0, host_full);
    endtask

    ////////////////////////////////////////////////////////////
    // Host driver with queue occupancy model
    ////////////////////////////////////////////////////////////

    // Scanout read in cycle c, counted from the first cycle after reset.
    function automatic logic scan_read_at(input int c);
        int h;
        int v;
        h = (c + 1) % `VGA_H_TOTAL;
        v = ((c + 1) / `VGA_H_TOTAL) % `VGA_V_TOTAL;
        return (h < `VGA_H_VIDEO) && (v < `VGA_V_VIDEO) && (h % SCALE == 0);
    endfunction

    task automatic drive_host();
        int cyc;
        logic pop;
        logic strobe;
        cyc = 0;
        forever begin
            @(posedge clk);
            pop = (q_count > 0) && !scan_read_at(cyc);
            if (host_wr)
                model[host_addr] = host_pixel; // Taken at this edge.
            q_count = q_count + int'(host_wr) - int'(pop);
            cyc = cyc + 1;
            strobe = 1'b0;
            if (q_count < `WFIFO_DEPTH) begin
                case (mode)
                    FILL:    strobe = (fill_addr < `FB_DEPTH);
                    HAMMER:  strobe = 1'b1;
                    RANDOM:  strobe = ($urandom % 2) == 1;
                    default: strobe = 1'b0;
                endcase
            end
            if (strobe) begin
                if (mode == FILL) begin
                    host_addr <= fb_addr_t'(fill_addr);
                    fill_addr = fill_addr + 1;
                end else begin
                    host_addr <= fb_addr_t'($urandom % `FB_DEPTH);
                end
                host_pixel <= pixel_t'($urandom);
            end
            host_wr <= strobe;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Raster checker
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!reset) begin
            t = t + 1;
            check_flag("host_full", q_count == `WFIFO_DEPTH, host_full);
            if (host_full)
                full_seen = 1'b1;
            if (de && (!hsync || !vsync))
                report_failure("de was high while a sync pulse was active");
            if (!de)
                check_pixel("rgb", '0, rgb); // Blanked.
            if (hsync_d && !hsync) begin
                if (hfall_t > 0)
                    check_h_period("hsync period", `VGA_H_TOTAL, h_count_t'(t - hfall_t));
                if (line_de && vfall_seen)
                    check_h_period("de to hsync", `VGA_H_FRONT, h_count_t'(t - defall_t));
                if (line_de)
                    de_lines = de_lines + 1;
                line_de = 1'b0;
                hfall_t = t;
                lines = lines + 1;
            end
            if (!hsync_d && hsync && hfall_t > 0)
                check_h_period("hsync pulse", `VGA_H_SYNC, h_count_t'(t - hfall_t));
            if (vsync_d && !vsync) begin
                if (vfall_seen) begin
                    check_v_period("vsync period", `VGA_V_TOTAL, v_count_t'(lines));
                    check_v_period("active lines", `VGA_V_VIDEO, v_count_t'(de_lines));
                end
                vfall_seen = 1'b1;
                lines = 0;
                de_lines = 0;
                new_frame = 1'b1;
            end
            if (!vsync_d && vsync && vfall_seen)
                check_v_period("vsync pulse", `VGA_V_SYNC, v_count_t'(lines));
            if (de && !de_d) begin
                row = new_frame ? 0 : row + 1;
                new_frame = 1'b0;
                col = 0;
            end
            if (de) begin
                if (check_en) begin
                    check_pixel("rgb", model[row / SCALE * `FB_WIDTH + col / SCALE], rgb);
                    checked = checked + 1;
                end
                col = col + 1;
                line_de = 1'b1;
            end
            if (!de && de_d) begin
                if (vfall_seen)
                    check_h_period("de run", `VGA_H_VIDEO, h_count_t'(col));
                defall_t = t;
            end
            hsync_d = hsync;
            vsync_d = vsync;
            de_d = de;
        end
    end

    task automatic verify_frame();
        checked = 0;
        check_en = 1'b1;
        @(negedge vsync);
        check_en = 1'b0;
        if (checked != `VGA_H_VIDEO * `VGA_V_VIDEO)
            report_failure("checked frame did not cover every visible pixel");
    endtask

    ////////////////////////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(99));
        reset = 1'b1;
        host_wr = 1'b0;
        host_addr = '0;
        host_pixel = '0;
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            if (i == 2)
                reset <= 1'b0;
            @(negedge clk);
            expect_reset_state();
        end
        fork
            drive_host();
        join_none
        @(negedge clk);
        mode = FILL;
        wait (fill_addr == `FB_DEPTH);
        @(negedge clk);
        mode = IDLE;
        @(negedge vsync);
        for (int round = 0; round < ROUNDS; round++) begin
            full_seen = 1'b0;
            @(negedge clk);
            mode = (round == 0) ? HAMMER : RANDOM;
            @(negedge vsync); // One frame of writes.
            @(negedge clk);
            mode = IDLE;
            if (round == 0 && !full_seen)
                report_failure("host_full never went high, back-pressure was not exercised");
            wait (q_count == 0);
            @(negedge vsync); // Quiet frame.
            verify_frame();
        end
        $display("STATUS: PASS");
        $finish;
    end

    initial begin
        #(TIMEOUT);
        report_failure("Watchdog expired before the test sequence finished");
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+hdl
hdl/vga_pkg.sv
hdl/vga_timing.sv
hdl/scanout_fetch.sv
hdl/write_fifo.sv
hdl/fb_arbiter.sv
hdl/frame_buffer.sv
hdl/display_top.sv
verification/display_tb.sv

/* Bender.yml */
package:
  name: vga_display

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/vga_pkg.sv
      - hdl/vga_timing.sv
      - hdl/scanout_fetch.sv
      - hdl/write_fifo.sv
      - hdl/fb_arbiter.sv
      - hdl/frame_buffer.sv
      - hdl/display_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/display_tb.sv
